// File: gsm_switch.f
+incdir+include
design/gsm_pkg.sv
design/gsm_tile.sv
design/rr_sch.sv
design/egress_port.sv
design/gsm_switch.sv
tb/tb_gsm_switch.sv

// File: Makefile
# Verilator build of the gsm_switch testbench

VERILATOR ?= verilator
TOP       ?= tb_gsm_switch
FILELIST  ?= gsm_switch.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
EXTRA     ?=

BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(wildcard design/*.sv) $(wildcard tb/*.sv) $(wildcard include/*.svh)
	$(VERILATOR) $(VFLAGS) $(EXTRA) -f $(FILELIST) --top-module $(TOP) \
		-Mdir $(BUILD_DIR) -o V$(TOP)

# exit status of the simulation is the pass or fail result
run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(BUILD_DIR)

// File: tb/tb_gsm_switch.sv
`timescale 1ns/1ps
`default_nettype none

`include "gsm_params.svh"

module tb_gsm_switch;
	import gsm_pkg::*;

	localparam int NP = `GSM_NUM_PORTS;
	localparam int NC = `GSM_CELLS;
	localparam int CLK_PERIOD = 8;
	// cycle budget of the whole sequence
	localparam int SEND_CALLS = 40;
	localparam int DRAIN_LIMIT = 100;
	localparam int DRAINS = 10;
	localparam int HOLD_CYCLES = 60;
	localparam int WATCHDOG_CYCLES = 20 + 3 * SEND_CALLS + DRAINS * DRAIN_LIMIT
		+ HOLD_CYCLES + 200;

	logic              clk_320M;
	logic              extern_rst_n;
	ing_bus_t          ingress;
	logic [NP-1:0]     egress_stall;
	egr_bus_t          egress;
	logic [NP-1:0]     ingress_drop;
	logic [NP-1:0]     egr_valid;

	// stimulus state
	logic [31:0]       rng_state;
	logic [7:0]        tx_mask [NP];
	logic [31:0]       tx_data [NP];
	logic              cell_sent;

	// ********************
	// reference model
	// ********************

	// queued cell ids per tile and egress port
	int                mq [2][NP][$];
	logic [31:0]       m_pay [512];
	logic [7:0]        m_rem [512];
	int                occ [2];
	int                rr_ptr [NP];
	int                next_id;
	int                pending_total;
	logic [NP-1:0]     hdr_pend;
	logic [7:0]        hdr_mask [NP];
	logic [NP-1:0]     exp_valid;
	logic [NP-1:0][31:0] exp_data;
	logic [NP-1:0]     exp_drop;

	gsm_switch dut_i (
		.i_clk_320M     (clk_320M),
		.i_extern_rst_n (extern_rst_n),
		.i_ingress      (ingress),
		.i_egress_stall (egress_stall),
		.o_egress       (egress),
		.o_ingress_drop (ingress_drop)
	);

	initial begin
		clk_320M = 1'b0;
		forever #(CLK_PERIOD / 2) clk_320M = ~clk_320M;
	end

	always_comb begin
		for (int p = 0; p < NP; p++) begin
			egr_valid[p] = egress[p].valid;
		end
	end

	// one step per edge, grants before pushes
	// acceptance sees slots as they stood at the start of the cycle
	always @(posedge clk_320M or negedge extern_rst_n) begin
		int   free0 [2];
		int   taken [2];
		int   t;
		int   id;
		logic found;
		if (!extern_rst_n) begin
			for (int tt = 0; tt < 2; tt++) begin
				occ[tt] = 0;
				for (int p = 0; p < NP; p++) begin
					mq[tt][p].delete();
				end
			end
			for (int p = 0; p < NP; p++) begin
				rr_ptr[p] = 0;
				hdr_mask[p] = '0;
			end
			next_id = 0;
			pending_total = 0;
			hdr_pend = '0;
			exp_valid = '0;
			exp_data = '0;
			exp_drop = '0;
		end else begin
			for (int tt = 0; tt < 2; tt++) begin
				free0[tt] = NC - occ[tt];
				taken[tt] = 0;
			end
			// round robin per egress port over the two tiles
			for (int p = 0; p < NP; p++) begin
				exp_valid[p] = 1'b0;
				found = 1'b0;
				for (int i = 0; i < 2; i++) begin
					t = (rr_ptr[p] + i) % 2;
					if (!egress_stall[p] && !found && mq[t][p].size() > 0) begin
						found = 1'b1;
						id = mq[t][p].pop_front();
						exp_valid[p] = 1'b1;
						exp_data[p] = m_pay[id];
						m_rem[id][p] = 1'b0;
						if (m_rem[id] == 8'h00) begin
							occ[t] = occ[t] - 1;
						end
						rr_ptr[p] = (t + 1) % 2;
						pending_total = pending_total - 1;
					end
				end
			end
			// ingress, lower ports claim slots first
			for (int k = 0; k < NP; k++) begin
				t = k / 4;
				exp_drop[k] = 1'b0;
				if (ingress[k].valid && !ingress[k].header && hdr_pend[k]) begin
					if (hdr_mask[k] != 8'h00 && taken[t] < free0[t]) begin
						id = next_id % 512;
						next_id = next_id + 1;
						taken[t] = taken[t] + 1;
						occ[t] = occ[t] + 1;
						m_pay[id] = ingress[k].word.data;
						m_rem[id] = hdr_mask[k];
						for (int p = 0; p < NP; p++) begin
							if (hdr_mask[k][p]) begin
								mq[t][p].push_back(id);
								pending_total = pending_total + 1;
							end
						end
					end else begin
						exp_drop[k] = 1'b1;
					end
				end
				if (ingress[k].valid) begin
					hdr_pend[k] = ingress[k].header;
				end
				if (ingress[k].valid && ingress[k].header) begin
					hdr_mask[k] = ingress[k].word.hdr.dest_mask;
				end
			end
		end
	end

	// ********************
	// checks
	// ********************

	task automatic fail_now(input string what);
		$display("%s", what);
		$display("Test FAILED");
		$fatal(1, "stopped at first error");
	endtask

	// covers latency, multicast fanout, stall and arbitration order
	for (genvar p = 0; p < NP; p++) begin : g_chk
		a_egress: assert property (@(posedge clk_320M) disable iff (!extern_rst_n)
			(egress[p].valid == exp_valid[p]) &&
			(!exp_valid[p] || (egress[p].data == exp_data[p])))
			else fail_now($sformatf("[FAIL] %0t o_egress[%0d] expected %b/%h got %b/%h",
				$time, p, $sampled(exp_valid[p]), $sampled(exp_data[p]),
				$sampled(egress[p].valid), $sampled(egress[p].data)));
	end

	a_drop: assert property (@(posedge clk_320M) disable iff (!extern_rst_n)
		ingress_drop == exp_drop)
		else fail_now($sformatf("[FAIL] %0t o_ingress_drop expected %b got %b",
			$time, $sampled(exp_drop), $sampled(ingress_drop)));

	// quiet outputs until the first cell
	a_quiet: assert property (@(posedge clk_320M) disable iff (!extern_rst_n)
		!cell_sent |-> (egr_valid == '0 && ingress_drop == '0))
		else fail_now($sformatf(
			"[FAIL] %0t o_egress valid / o_ingress_drop expected %b/%b got %b/%b",
			$time, 8'h00, 8'h00, $sampled(egr_valid), $sampled(ingress_drop)));

	// ********************
	// stimulus
	// ********************

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x;
		y = y ^ (y << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic logic [31:0] rand_word();
		rng_state = xorshift32(rng_state);
		return rng_state;
	endfunction

	task automatic load_cell(input int k, input logic [7:0] mask);
		tx_mask[k] = mask;
		tx_data[k] = rand_word();
	endtask

	// random mask, never empty
	task automatic load_random_cell(input int k);
		logic [31:0] r;
		r = rand_word();
		load_cell(k, (r[7:0] == 8'h00) ? 8'h01 : r[7:0]);
	endtask

	// header beat, payload beat, then one idle beat
	task automatic send_cells(input logic [NP-1:0] en);
		logic [31:0] tag_r;
		@(negedge clk_320M);
		for (int k = 0; k < NP; k++) begin
			if (en[k]) begin
				tag_r = rand_word();
				ingress[k].valid = 1'b1;
				ingress[k].header = 1'b1;
				ingress[k].word.hdr.dest_mask = tx_mask[k];
				ingress[k].word.hdr.tag = tag_r[23:0];
			end
		end
		cell_sent = 1'b1;
		@(negedge clk_320M);
		for (int k = 0; k < NP; k++) begin
			if (en[k]) begin
				ingress[k].header = 1'b0;
				ingress[k].word.data = tx_data[k];
			end
		end
		@(negedge clk_320M);
		ingress = '0;
	endtask

	task automatic set_stall(input logic [NP-1:0] s);
		@(negedge clk_320M);
		egress_stall = s;
	endtask

	// wait for every expected cell to leave, bounded
	task automatic wait_drain();
		int n;
		n = 0;
		while (pending_total != 0 && n < DRAIN_LIMIT) begin
			@(negedge clk_320M);
			n++;
		end
		if (pending_total != 0) begin
			fail_now($sformatf("queued cells did not drain within %0d cycles", DRAIN_LIMIT));
		end else begin
			repeat (3) @(negedge clk_320M);
		end
	endtask

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		fail_now("watchdog expired before the test sequence finished");
	end

	initial begin
		logic [31:0] r;
		rng_state = 32'd2;
		extern_rst_n = 1'b0;
		ingress = '0;
		egress_stall = '0;
		cell_sent = 1'b0;
		for (int k = 0; k < NP; k++) begin
			tx_mask[k] = '0;
			tx_data[k] = '0;
		end
		repeat (4) @(posedge clk_320M);
		@(negedge clk_320M);
		extern_rst_n = 1'b1;
		// idle after reset, outputs stay low
		repeat (6) @(negedge clk_320M);

		// unicast, one cell per tile
		load_cell(2, 8'h20);
		send_cells(8'h04);
		wait_drain();
		load_cell(6, 8'h02);
		send_cells(8'h40);
		wait_drain();

		// multicast, disjoint then overlapping masks
		load_cell(1, 8'hA5);
		load_cell(7, 8'h5A);
		send_cells(8'h82);
		wait_drain();
		load_cell(0, 8'hFF);
		load_cell(4, 8'h0F);
		send_cells(8'h11);
		wait_drain();
		// empty mask is dropped
		load_cell(3, 8'h00);
		send_cells(8'h08);
		wait_drain();

		// port 3 held, cells pile up from both tiles
		set_stall(8'h08);
		for (int k = 0; k < 4; k++) begin
			load_cell(k, 8'h08);
		end
		send_cells(8'h0F);
		load_cell(1, 8'h08);
		load_cell(5, 8'h08);
		send_cells(8'h22);
		repeat (10) @(negedge clk_320M);
		set_stall(8'h00);
		wait_drain();

		// fill all 16 slots of tile 0, the next cell drops
		set_stall(8'hFF);
		for (int round = 0; round < 4; round++) begin
			for (int k = 0; k < 4; k++) begin
				load_random_cell(k);
			end
			send_cells(8'h0F);
		end
		load_cell(2, 8'h01);
		send_cells(8'h04);
		repeat (4) @(negedge clk_320M);
		set_stall(8'h00);
		wait_drain();
		// freed slots take cells again
		for (int k = 0; k < 4; k++) begin
			load_random_cell(k);
		end
		send_cells(8'h0F);
		wait_drain();

		// both tiles into port 6, backlog first
		set_stall(8'hFF);
		for (int round = 0; round < 20; round++) begin
			r = rand_word();
			load_cell(int'(r[1:0]), 8'h40);
			load_cell(4 + int'(r[3:2]), 8'h40);
			send_cells((8'h01 << r[1:0]) | (8'h10 << r[3:2]));
			// second half runs with port 6 stalled at random
			if (round >= 8) begin
				set_stall({1'b1, r[8], 6'h3F});
			end
		end
		set_stall(8'hBF);
		wait_drain();
		set_stall(8'h00);

		// all ports open, nothing may come out any more
		repeat (3) @(negedge clk_320M);
		$display("Test OK");
		$finish;
	end

endmodule

`default_nettype wire

// File: design/gsm_switch.sv
`timescale 1ns/1ps
`default_nettype none

`include "gsm_params.svh"

module gsm_switch (
	input  wire                        i_clk_320M,
	input  wire                        i_extern_rst_n,
	input  wire gsm_pkg::ing_bus_t     i_ingress,
	input  wire [`GSM_NUM_PORTS-1:0]   i_egress_stall,
	output gsm_pkg::egr_bus_t          o_egress,
	output logic [`GSM_NUM_PORTS-1:0]  o_ingress_drop
);
	localparam int NT = `GSM_NUM_TILES;
	localparam int NP = `GSM_NUM_PORTS;
	localparam int NI = `GSM_PORTS_PER_TILE;
	localparam int DW = `GSM_DWIDTH;

	// ********************
	// tile side view
	// ********************

	logic [NT-1:0][NP-1:0]         q_valid;
	logic [NT-1:0][NP-1:0]         q_pop;
	logic [NT-1:0][NP-1:0][DW-1:0] q_data;

	// ********************
	// egress side view
	// ********************

	logic [NP-1:0][NT-1:0]         eg_req;
	logic [NP-1:0][NT-1:0]         eg_grant;
	logic [NP-1:0][NT-1:0][DW-1:0] eg_data;

	// one tile per group of ingress ports
	for (genvar t = 0; t < NT; t++) begin : g_tile
		gsm_tile gsm_tile_i (
			.i_clk_320M     (i_clk_320M),
			.i_extern_rst_n (i_extern_rst_n),
			.i_ingress      (i_ingress[t*NI +: NI]),
			.i_q_pop        (q_pop[t]),
			.o_q_valid      (q_valid[t]),
			.o_q_data       (q_data[t]),
			.o_ingress_drop (o_ingress_drop[t*NI +: NI])
		);
	end

	// transpose tile by port into port by tile
	// grants go back the other way as queue pops
	for (genvar p = 0; p < NP; p++) begin : g_xpose
		for (genvar t = 0; t < NT; t++) begin : g_tile_bit
			assign eg_req[p][t]  = q_valid[t][p];
			assign eg_data[p][t] = q_data[t][p];
			assign q_pop[t][p]   = eg_grant[p][t];
		end
	end

	// one scheduler and output register per egress port
	for (genvar p = 0; p < NP; p++) begin : g_egress
		egress_port egress_port_i (
			.i_clk_320M     (i_clk_320M),
			.i_extern_rst_n (i_extern_rst_n),
			.i_req          (eg_req[p]),
			.i_data         (eg_data[p]),
			.i_stall        (i_egress_stall[p]),
			.o_grant        (eg_grant[p]),
			.o_egress       (o_egress[p])
		);
	end

endmodule

`default_nettype wire

// File: design/egress_port.sv
`timescale 1ns/1ps
`default_nettype none

`include "gsm_params.svh"

module egress_port (
	input  wire                                          i_clk_320M,
	input  wire                                          i_extern_rst_n,
	input  wire [`GSM_NUM_TILES-1:0]                     i_req,
	input  wire [`GSM_NUM_TILES-1:0][`GSM_DWIDTH-1:0]    i_data,
	input  wire                                          i_stall,
	output logic [`GSM_NUM_TILES-1:0]                    o_grant,
	output gsm_pkg::egr_beat_t                           o_egress
);
	import gsm_pkg::*;

	// selected beat before the output register
	egr_beat_t              beat_d;
	logic                   valid_q;
	logic [`GSM_DWIDTH-1:0] data_q;

	// ********************
	// tile arbitration
	// ********************

	rr_sch #(
		.NUM_REQ(`GSM_NUM_TILES)
	) rr_sch_i (
		.i_clk_320M     (i_clk_320M),
		.i_extern_rst_n (i_extern_rst_n),
		.i_req          (i_req),
		.i_stall        (i_stall),
		.o_grant        (o_grant)
	);

	// head word of the granted tile
	// grant is one hot, so a plain priority pick is enough
	always_comb begin
		beat_d.valid = |o_grant;
		beat_d.data = '0;
		for (int t = 0; t < `GSM_NUM_TILES; t++) begin
			if (o_grant[t]) begin
				beat_d.data = i_data[t];
			end
		end
	end

	// ********************
	// output register
	// ********************

	always_ff @(posedge i_clk_320M or negedge i_extern_rst_n) begin
		if (!i_extern_rst_n) begin
			valid_q <= 1'b0;
		end else begin
			valid_q <= beat_d.valid;
		end
	end

	always_ff @(posedge i_clk_320M) begin
		data_q <= beat_d.data;
	end

	assign o_egress = '{valid: valid_q, data: data_q};

endmodule

`default_nettype wire

// File: design/rr_sch.sv
`timescale 1ns/1ps
`default_nettype none

`include "gsm_params.svh"

module rr_sch #(
	parameter int NUM_REQ = `GSM_NUM_TILES
) (
	input  wire                i_clk_320M,
	input  wire                i_extern_rst_n,
	input  wire [NUM_REQ-1:0]  i_req,
	input  wire                i_stall,
	output logic [NUM_REQ-1:0] o_grant
);
	localparam int PW = (NUM_REQ > 1) ? $clog2(NUM_REQ) : 1;

	// requester with top priority this cycle
	logic [PW-1:0] ptr_q;
	logic [PW-1:0] ptr_nxt;

	// ********************
	// grant search
	// ********************

	// circular scan starting at the pointer
	// stall holds back every grant
	always_comb begin
		int   idx;
		logic found;
		o_grant = '0;
		ptr_nxt = ptr_q;
		found = 1'b0;
		idx = 0;
		if (!i_stall) begin
			for (int i = 0; i < NUM_REQ; i++) begin
				idx = (int'(ptr_q) + i) % NUM_REQ;
				if (!found && i_req[idx]) begin
					found = 1'b1;
					o_grant[idx] = 1'b1;
					// next round starts just past the winner
					ptr_nxt = (idx == NUM_REQ - 1) ? '0 : PW'(idx + 1);
				end
			end
		end
	end

	// pointer only moves on a grant
	always_ff @(posedge i_clk_320M or negedge i_extern_rst_n) begin
		if (!i_extern_rst_n) begin
			ptr_q <= '0;
		end else begin
			ptr_q <= ptr_nxt;
		end
	end

	// ********************
	// checks
	// ********************

	a_grant_onehot: assert property (@(posedge i_clk_320M) disable iff (!i_extern_rst_n)
		$onehot0(o_grant));

	a_grant_in_req: assert property (@(posedge i_clk_320M) disable iff (!i_extern_rst_n)
		(o_grant & ~i_req) == '0);

	a_no_grant_stall: assert property (@(posedge i_clk_320M) disable iff (!i_extern_rst_n)
		i_stall |-> (o_grant == '0));

endmodule

`default_nettype wire

// File: design/gsm_tile.sv
`timescale 1ns/1ps
`default_nettype none

`include "gsm_params.svh"

module gsm_tile (
	input  wire                                               i_clk_320M,
	input  wire                                               i_extern_rst_n,
	input  wire gsm_pkg::ing_beat_t [`GSM_PORTS_PER_TILE-1:0] i_ingress,
	input  wire [`GSM_NUM_PORTS-1:0]                          i_q_pop,
	output logic [`GSM_NUM_PORTS-1:0]                         o_q_valid,
	output logic [`GSM_NUM_PORTS-1:0][`GSM_DWIDTH-1:0]        o_q_data,
	output logic [`GSM_PORTS_PER_TILE-1:0]                    o_ingress_drop
);
	import gsm_pkg::*;

	localparam int NI = `GSM_PORTS_PER_TILE;
	localparam int NP = `GSM_NUM_PORTS;
	localparam int NC = `GSM_CELLS;
	localparam int AW = `GSM_AWIDTH;
	localparam int DW = `GSM_DWIDTH;

	// ********************
	// ingress side
	// ********************

	// header seen, payload expected next
	logic [NI-1:0]         hdr_pend_q;
	// destination mask held from header beat
	logic [NI-1:0][NP-1:0] hdr_mask_q;
	// payload beat of a cell this cycle
	logic [NI-1:0]         pay_beat;
	// cell got a slot and a nonzero mask
	logic [NI-1:0]         acc;
	slot_t [NI-1:0]        slot_sel;

	// shared cell memory
	logic [DW-1:0]         cell_mem [NC];
	// per slot, egress ports still to send it
	logic [NC-1:0][NP-1:0] pend_mask_q;
	logic [NC-1:0][NP-1:0] pend_nxt;
	logic [NC-1:0]         free_vec;

	// ********************
	// egress queues
	// ********************

	slot_t                 q_mem [NP][NC];
	// one extra bit tells full from empty
	logic [NP-1:0][AW:0]   wr_ptr_q;
	logic [NP-1:0][AW:0]   rd_ptr_q;
	slot_t [NP-1:0]        head_slot;
	logic [NP-1:0][NI-1:0] push_sel;
	slot_t [NP-1:0][NI-1:0] push_idx;
	logic [NP-1:0][AW:0]   push_cnt;
	logic [NP-1:0]         q_ovf;

	// lowest set bit of a free vector
	function automatic slot_t lowest_free(input logic [NC-1:0] v);
		slot_t idx;
		idx = '0;
		// scan down so the lowest set bit wins
		for (int s = NC - 1; s >= 0; s--) begin
			if (v[s]) begin
				idx = slot_t'(s);
			end
		end
		return idx;
	endfunction

	// a slot is free once no egress port still owes it
	always_comb begin
		for (int s = 0; s < NC; s++) begin
			free_vec[s] = ~|pend_mask_q[s];
		end
	end

	// header tracking, valid beat with header set arms the next one
	always_ff @(posedge i_clk_320M or negedge i_extern_rst_n) begin
		if (!i_extern_rst_n) begin
			hdr_pend_q <= '0;
		end else begin
			for (int k = 0; k < NI; k++) begin
				if (i_ingress[k].valid) begin
					hdr_pend_q[k] <= i_ingress[k].header;
				end
			end
		end
	end

	always_ff @(posedge i_clk_320M) begin
		for (int k = 0; k < NI; k++) begin
			if (i_ingress[k].valid && i_ingress[k].header) begin
				hdr_mask_q[k] <= i_ingress[k].word.hdr.dest_mask;
			end
		end
	end

	always_comb begin
		for (int k = 0; k < NI; k++) begin
			pay_beat[k] = i_ingress[k].valid & ~i_ingress[k].header & hdr_pend_q[k];
		end
	end

	// slot allocation
	// lower ports claim first when several payloads share a cycle
	always_comb begin
		logic [NC-1:0] avail;
		avail = free_vec;
		for (int k = 0; k < NI; k++) begin
			acc[k] = 1'b0;
			slot_sel[k] = lowest_free(avail);
			if (pay_beat[k] && (|hdr_mask_q[k]) && (|avail)) begin
				acc[k] = 1'b1;
				avail[slot_sel[k]] = 1'b0;
			end
		end
	end

	// payload write
	always_ff @(posedge i_clk_320M) begin
		for (int k = 0; k < NI; k++) begin
			if (acc[k]) begin
				cell_mem[slot_sel[k]] <= i_ingress[k].word.data;
			end
		end
	end

	// drop pulse, one cycle after the payload beat
	always_ff @(posedge i_clk_320M or negedge i_extern_rst_n) begin
		if (!i_extern_rst_n) begin
			o_ingress_drop <= '0;
		end else begin
			o_ingress_drop <= pay_beat & ~acc;
		end
	end

	// outstanding masks
	// pops clear bits, new cells load their full mask
	always_comb begin
		pend_nxt = pend_mask_q;
		for (int p = 0; p < NP; p++) begin
			if (i_q_pop[p]) begin
				pend_nxt[head_slot[p]][p] = 1'b0;
			end
		end
		// new slots were free, so no overlap with pops
		for (int k = 0; k < NI; k++) begin
			if (acc[k]) begin
				pend_nxt[slot_sel[k]] = hdr_mask_q[k];
			end
		end
	end

	always_ff @(posedge i_clk_320M or negedge i_extern_rst_n) begin
		if (!i_extern_rst_n) begin
			pend_mask_q <= '0;
		end else begin
			pend_mask_q <= pend_nxt;
		end
	end

	// queue push, up to one entry per ingress port
	// entries land in ingress port order
	always_comb begin
		logic [AW:0] off;
		for (int p = 0; p < NP; p++) begin
			off = '0;
			for (int k = 0; k < NI; k++) begin
				push_sel[p][k] = acc[k] & hdr_mask_q[k][p];
				push_idx[p][k] = wr_ptr_q[p][AW-1:0] + off[AW-1:0];
				if (push_sel[p][k]) begin
					off = off + 1'b1;
				end
			end
			push_cnt[p] = off;
		end
	end

	always_ff @(posedge i_clk_320M) begin
		for (int p = 0; p < NP; p++) begin
			for (int k = 0; k < NI; k++) begin
				if (push_sel[p][k]) begin
					q_mem[p][push_idx[p][k]] <= slot_sel[k];
				end
			end
		end
	end

	always_ff @(posedge i_clk_320M or negedge i_extern_rst_n) begin
		if (!i_extern_rst_n) begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
		end else begin
			for (int p = 0; p < NP; p++) begin
				wr_ptr_q[p] <= wr_ptr_q[p] + push_cnt[p];
				rd_ptr_q[p] <= rd_ptr_q[p] + {{AW{1'b0}}, i_q_pop[p]};
			end
		end
	end

	// queue heads toward the egress ports
	always_comb begin
		logic [AW:0] q_cnt;
		for (int p = 0; p < NP; p++) begin
			q_cnt = wr_ptr_q[p] - rd_ptr_q[p];
			head_slot[p] = q_mem[p][rd_ptr_q[p][AW-1:0]];
			o_q_valid[p] = (q_cnt != '0);
			o_q_data[p] = cell_mem[head_slot[p]];
			q_ovf[p] = (push_cnt[p] != '0) && ((q_cnt + push_cnt[p]) > NC);
		end
	end

	// ********************
	// checks
	// ********************

	// grant from the egress scheduler only on a queue with a cell
	a_pop_on_valid: assert property (@(posedge i_clk_320M) disable iff (!i_extern_rst_n)
		(i_q_pop & ~o_q_valid) == '0);

	// a slot sits in a queue at most once, so the queue never overflows
	a_no_push_full: assert property (@(posedge i_clk_320M) disable iff (!i_extern_rst_n)
		q_ovf == '0);

endmodule

`default_nettype wire

// File: design/gsm_pkg.sv
`default_nettype none

`include "gsm_params.svh"

package gsm_pkg;

	// ********************
	// cell word views
	// ********************

	// index of one slot in a tile memory
	typedef logic [`GSM_AWIDTH-1:0] slot_t;

	// header view of an ingress word
	// one mask bit per egress port, tag fills the rest
	typedef struct packed {
		logic [`GSM_NUM_PORTS-1:0]              dest_mask;
		logic [`GSM_DWIDTH-`GSM_NUM_PORTS-1:0] tag;
	} hdr_t;

	// same 32 bits, read as header or as payload
	typedef union packed {
		hdr_t                   hdr;
		logic [`GSM_DWIDTH-1:0] data;
	} cell_word_u;

	// ********************
	// port beats
	// ********************

	// one ingress beat
	// header high marks the destination beat of a cell
	typedef struct packed {
		logic       valid;
		logic       header;
		cell_word_u word;
	} ing_beat_t;

	// one egress beat
	typedef struct packed {
		logic                   valid;
		logic [`GSM_DWIDTH-1:0] data;
	} egr_beat_t;

	// all ports of the switch
	typedef ing_beat_t [`GSM_NUM_PORTS-1:0] ing_bus_t;
	typedef egr_beat_t [`GSM_NUM_PORTS-1:0] egr_bus_t;

endpackage

`default_nettype wire

// File: include/gsm_params.svh
`ifndef GSM_PARAMS_SVH
`define GSM_PARAMS_SVH

// ********************
// switch dimensions
// ********************

// number of groups sharing one cell memory each
`define GSM_NUM_TILES 2

// ingress ports feeding one tile
`define GSM_PORTS_PER_TILE 4

// total ingress ports, same count on egress
`define GSM_NUM_PORTS 8

// ********************
// datapath and memory
// ********************

// ingress and egress word width
`define GSM_DWIDTH 32

// cell slots in each tile memory
`define GSM_CELLS 16

// slot index width, log2 of the slot count
`define GSM_AWIDTH 4

`endif
